// File: filelist.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/stage_reg.sv
hdl/hazard_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/pipe_core.sv
verification/tb_clock_gen.sv
verification/pipe_core_tb.sv

// File: hdl/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and register file
`define CORE_XLEN 32
`define CORE_NREGS 32

// data memory depth in words
`define CORE_DMEM_WORDS 64

// extra execute cycles for MUL
`define CORE_MUL_CYCLES 4

`define CORE_EXC_VECTOR 32'h0000_0180  // handler entry on overflow

`endif

// File: hdl/decode_stage.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module decode_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  logic                  flush,
    input  logic                  inst_valid,
    input  pipe_pkg::word_t       inst_pc,
    input  pipe_pkg::word_t       inst_word,
    input  logic                  ex_fwd_valid,
    input  isa_pkg::reg_idx_t     ex_fwd_idx,
    input  pipe_pkg::word_t       ex_fwd_data,
    input  logic                  res_fwd_valid,
    input  isa_pkg::reg_idx_t     res_fwd_idx,
    input  pipe_pkg::word_t       res_fwd_data,
    input  logic                  wb_we,
    input  isa_pkg::reg_idx_t     wb_waddr,
    input  pipe_pkg::word_t       wb_wdata,
    output logic                  dx_valid,
    output pipe_pkg::dx_payload_t dx_payload,
    output logic                  reads_rs,
    output logic                  reads_rt,
    output isa_pkg::reg_idx_t     rs,
    output isa_pkg::reg_idx_t     rt
);

    logic              buf_valid;
    pipe_pkg::word_t   buf_pc;
    isa_pkg::r_fmt_t   rfmt;
    isa_pkg::i_fmt_t   ifmt;
    isa_pkg::op_e      op;
    isa_pkg::reg_idx_t dest;
    pipe_pkg::word_t   regs [`CORE_NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            buf_valid <= 1'b0;
        end else if (en) begin
            buf_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            buf_pc <= inst_pc;
            rfmt   <= inst_word;
        end
    end
    assign ifmt = rfmt;  // immediate view of the same word

    always_comb begin
        op = isa_pkg::OP_NOP;  // anything unknown decays to a nop
        case (rfmt.opcode)
            isa_pkg::OPC_SPECIAL: begin
                case (rfmt.funct)
                    isa_pkg::FN_ADDU: op = isa_pkg::OP_ADDU;
                    isa_pkg::FN_ADD:  op = isa_pkg::OP_ADD;
                    isa_pkg::FN_SUBU: op = isa_pkg::OP_SUBU;
                    isa_pkg::FN_AND:  op = isa_pkg::OP_AND;
                    isa_pkg::FN_OR:   op = isa_pkg::OP_OR;
                    isa_pkg::FN_SLT:  op = isa_pkg::OP_SLT;
                    default:          op = isa_pkg::OP_NOP;
                endcase
            end
            isa_pkg::OPC_SPECIAL2: begin
                if (rfmt.funct == isa_pkg::FN_MUL) begin
                    op = isa_pkg::OP_MUL;
                end
            end
            isa_pkg::OPC_ADDIU: op = isa_pkg::OP_ADDIU;
            isa_pkg::OPC_LW:    op = isa_pkg::OP_LW;
            isa_pkg::OPC_SW:    op = isa_pkg::OP_SW;
            isa_pkg::OPC_BEQ:   op = isa_pkg::OP_BEQ;
            isa_pkg::OPC_BNE:   op = isa_pkg::OP_BNE;
            default:            op = isa_pkg::OP_NOP;
        endcase
    end

    assign rs       = rfmt.rs;
    assign rt       = rfmt.rt;
    assign reads_rs = buf_valid && op != isa_pkg::OP_NOP;
    assign reads_rt = buf_valid
                      && !(op inside {isa_pkg::OP_NOP, isa_pkg::OP_ADDIU, isa_pkg::OP_LW});
    assign dest     = (op inside {isa_pkg::OP_ADDIU, isa_pkg::OP_LW}) ? rfmt.rt : rfmt.rd;

    // youngest producer first, then the array
    function automatic pipe_pkg::word_t operand(isa_pkg::reg_idx_t idx);
        pipe_pkg::word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (ex_fwd_valid && ex_fwd_idx == idx) begin
            val = ex_fwd_data;
        end else if (res_fwd_valid && res_fwd_idx == idx) begin
            val = res_fwd_data;  // also covers the same-cycle register write
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        dx_payload.pc     = buf_pc;
        dx_payload.op     = op;
        dx_payload.rs_val = operand(rfmt.rs);
        dx_payload.rt_val = operand(rfmt.rt);
        dx_payload.imm    = {{(`CORE_XLEN-16){ifmt.imm[15]}}, ifmt.imm};
        dx_payload.dest   = dest;
        dx_payload.we     = dest != '0 && !(op inside {isa_pkg::OP_NOP, isa_pkg::OP_SW,
                                                      isa_pkg::OP_BEQ, isa_pkg::OP_BNE});
    end

    assign dx_valid = buf_valid && en;  // bubble while held for load-use

    always_ff @(posedge clk) begin
        if (wb_we && wb_waddr != '0) begin
            regs[wb_waddr] <= wb_wdata;
        end
    end

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module execute_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  logic                  in_valid,
    input  pipe_pkg::dx_payload_t in_payload,
    output logic                  xr_valid,
    output pipe_pkg::xr_payload_t xr_payload,
    output logic                  is_load,
    output isa_pkg::reg_idx_t     dest,
    output logic                  branch_taken,
    output pipe_pkg::word_t       branch_target,
    output logic                  mul_busy,
    output logic                  fwd_valid,
    output pipe_pkg::word_t       fwd_data
);

    localparam int CNT_W = $clog2(`CORE_MUL_CYCLES + 1);

    pipe_pkg::word_t a, b, sum, result, prod_q;
    logic [CNT_W-1:0] mul_cnt;
    logic             add_ovf;

    assign a       = in_payload.rs_val;
    assign b       = in_payload.rt_val;
    assign sum     = a + b;
    assign add_ovf = (a[`CORE_XLEN-1] == b[`CORE_XLEN-1])
                     && (sum[`CORE_XLEN-1] != a[`CORE_XLEN-1]);  // signed wrap

    always_comb begin
        case (in_payload.op)
            isa_pkg::OP_ADDU, isa_pkg::OP_ADD: result = sum;
            isa_pkg::OP_SUBU: result = a - b;
            isa_pkg::OP_AND:  result = a & b;
            isa_pkg::OP_OR:   result = a | b;
            isa_pkg::OP_SLT:  result = {{(`CORE_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            isa_pkg::OP_ADDIU, isa_pkg::OP_LW, isa_pkg::OP_SW: result = a + in_payload.imm;
            isa_pkg::OP_MUL:  result = prod_q;
            default:          result = '0;
        endcase
    end

    // multiply holds execute until the counter reaches the latency
    assign mul_busy = in_valid && in_payload.op == isa_pkg::OP_MUL
                      && mul_cnt != CNT_W'(`CORE_MUL_CYCLES);

    always_ff @(posedge clk) begin
        if (!rst_n || en) begin
            mul_cnt <= '0;  // restarts with each new instruction
        end else if (mul_busy) begin
            mul_cnt <= mul_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_busy) begin
            prod_q <= a * b;  // low word only
        end
    end

    assign is_load       = in_valid && in_payload.op == isa_pkg::OP_LW;
    assign dest          = in_payload.dest;
    assign branch_taken  = in_valid && ((in_payload.op == isa_pkg::OP_BEQ && a == b)
                                     || (in_payload.op == isa_pkg::OP_BNE && a != b));
    assign branch_target = in_payload.pc + 4 + {in_payload.imm[`CORE_XLEN-3:0], 2'b00};
    assign fwd_valid     = in_valid && in_payload.we && !is_load;  // load data not here yet
    assign fwd_data      = result;

    assign xr_valid = in_valid;
    always_comb begin
        xr_payload.pc         = in_payload.pc;
        xr_payload.op         = in_payload.op;
        xr_payload.alu_res    = result;
        xr_payload.store_data = b;
        xr_payload.dest       = in_payload.dest;
        xr_payload.we         = in_payload.we;
        xr_payload.ovf        = in_payload.op == isa_pkg::OP_ADD && add_ovf;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mul_busy) |-> ##[1:`CORE_MUL_CYCLES] !mul_busy);

endmodule

// File: hdl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              dec_reads_rs,
    input  logic              dec_reads_rt,
    input  isa_pkg::reg_idx_t dec_rs,
    input  isa_pkg::reg_idx_t dec_rt,
    input  logic              ex_is_load,
    input  isa_pkg::reg_idx_t ex_dest,
    input  logic              ex_branch_taken,
    input  logic              ex_mul_busy,
    input  logic              res_except,
    input  logic              res_commit_stall,
    output logic              dec_en,
    output logic              ex_en,
    output logic              res_en,
    output logic              dec_flush,
    output logic              ex_flush,
    output logic              res_flush
);

    logic ready_q;  // keeps fetch closed for one cycle after reset
    logic lw_stall;
    logic longest_stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b1;
        end
    end

    // load result not available for forwarding yet
    assign lw_stall = ex_is_load && (ex_dest != '0)
                      && ((dec_reads_rs && dec_rs == ex_dest)
                      || (dec_reads_rt && dec_rt == ex_dest));
    assign longest_stall = ex_mul_busy || res_commit_stall;

    assign dec_en = ready_q && !(lw_stall || longest_stall);
    assign ex_en  = !longest_stall;
    assign res_en = !longest_stall || res_except;  // trap must drain

    assign dec_flush = res_except || ex_branch_taken;
    assign ex_flush  = res_except || ex_branch_taken;
    assign res_flush = res_except;

    // the load leaves execute with a bubble behind it, so load-use costs one cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        (lw_stall && ex_en) |=> !lw_stall);

endmodule

// File: hdl/isa_pkg.sv
package isa_pkg;

    typedef logic [4:0] reg_idx_t;

    // one value per supported instruction
    typedef enum logic [3:0] {
        OP_NOP, OP_ADDU, OP_ADD, OP_SUBU, OP_AND, OP_OR, OP_SLT,
        OP_ADDIU, OP_LW, OP_SW, OP_BEQ, OP_BNE, OP_MUL
    } op_e;

    typedef struct packed {
        logic [5:0] opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm;
    } i_fmt_t;

    localparam logic [5:0] OPC_SPECIAL  = 6'h00;
    localparam logic [5:0] OPC_SPECIAL2 = 6'h1c;  // mul lives here
    localparam logic [5:0] OPC_BEQ      = 6'h04;
    localparam logic [5:0] OPC_BNE      = 6'h05;
    localparam logic [5:0] OPC_ADDIU    = 6'h09;
    localparam logic [5:0] OPC_LW       = 6'h23;
    localparam logic [5:0] OPC_SW       = 6'h2b;

    localparam logic [5:0] FN_MUL  = 6'h02;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage

// File: hdl/pipe_core.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module pipe_core (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              inst_valid,
    input  pipe_pkg::word_t   inst_pc,
    input  pipe_pkg::word_t   inst_word,
    output logic              inst_ready,
    output logic              commit_valid,
    output pipe_pkg::word_t   commit_pc,
    output isa_pkg::reg_idx_t commit_rd,
    output pipe_pkg::word_t   commit_data,
    input  logic              commit_ready,
    output logic              redirect_valid,
    output pipe_pkg::word_t   redirect_pc,
    output logic              redirect_exc
);

    logic dec_en, ex_en, res_en, dec_flush, ex_flush, res_flush, xr_flush;
    logic reads_rs, reads_rt, dx_valid_d, dx_valid_q, xr_valid_d, xr_valid_q;
    logic is_load, branch_taken, mul_busy, ex_fwd_valid;
    logic except, commit_stall, wb_we;
    isa_pkg::reg_idx_t     rs, rt, ex_dest, wb_waddr;
    pipe_pkg::word_t       branch_target, ex_fwd_data, except_pc, wb_wdata;
    pipe_pkg::dx_payload_t dx_d, dx_q;
    pipe_pkg::xr_payload_t xr_d, xr_q;

    assign inst_ready = dec_en;

    decode_stage decode_i (
        .clk(clk), .rst_n(rst_n), .en(dec_en), .flush(dec_flush),
        .inst_valid(inst_valid), .inst_pc(inst_pc), .inst_word(inst_word),
        .ex_fwd_valid(ex_fwd_valid), .ex_fwd_idx(ex_dest), .ex_fwd_data(ex_fwd_data),
        .res_fwd_valid(wb_we), .res_fwd_idx(wb_waddr), .res_fwd_data(wb_wdata),
        .wb_we(wb_we), .wb_waddr(wb_waddr), .wb_wdata(wb_wdata),
        .dx_valid(dx_valid_d), .dx_payload(dx_d),
        .reads_rs(reads_rs), .reads_rt(reads_rt), .rs(rs), .rt(rt)
    );

    stage_reg #(.payload_t(pipe_pkg::dx_payload_t)) dx_reg_i (
        .clk(clk), .rst_n(rst_n), .en(ex_en), .flush(ex_flush),
        .in_valid(dx_valid_d), .in_payload(dx_d), .out_valid(dx_valid_q), .out_payload(dx_q)
    );

    execute_stage execute_i (
        .clk(clk), .rst_n(rst_n), .en(ex_en), .in_valid(dx_valid_q), .in_payload(dx_q),
        .xr_valid(xr_valid_d), .xr_payload(xr_d), .is_load(is_load), .dest(ex_dest),
        .branch_taken(branch_taken), .branch_target(branch_target), .mul_busy(mul_busy),
        .fwd_valid(ex_fwd_valid), .fwd_data(ex_fwd_data)
    );

    // an instruction held behind a multiply has already retired into the commit buffer
    assign xr_flush = res_flush || (wb_we && !res_en);

    stage_reg #(.payload_t(pipe_pkg::xr_payload_t)) xr_reg_i (
        .clk(clk), .rst_n(rst_n), .en(res_en), .flush(xr_flush),
        .in_valid(xr_valid_d), .in_payload(xr_d), .out_valid(xr_valid_q), .out_payload(xr_q)
    );

    result_stage result_i (
        .clk(clk), .rst_n(rst_n), .in_valid(xr_valid_q), .in_payload(xr_q),
        .commit_ready(commit_ready), .commit_valid(commit_valid), .commit_pc(commit_pc),
        .commit_rd(commit_rd), .commit_data(commit_data),
        .except(except), .except_pc(except_pc), .commit_stall(commit_stall),
        .wb_we(wb_we), .wb_waddr(wb_waddr), .wb_wdata(wb_wdata)
    );

    hazard_unit hazard_i (
        .clk(clk), .rst_n(rst_n),
        .dec_reads_rs(reads_rs), .dec_reads_rt(reads_rt), .dec_rs(rs), .dec_rt(rt),
        .ex_is_load(is_load), .ex_dest(ex_dest), .ex_branch_taken(branch_taken),
        .ex_mul_busy(mul_busy), .res_except(except), .res_commit_stall(commit_stall),
        .dec_en(dec_en), .ex_en(ex_en), .res_en(res_en),
        .dec_flush(dec_flush), .ex_flush(ex_flush), .res_flush(res_flush)
    );

    // older exception beats a younger branch
    assign redirect_valid = except || branch_taken;
    assign redirect_pc    = except ? except_pc : branch_target;
    assign redirect_exc   = except;

endmodule

// File: hdl/pipe_pkg.sv
`include "core_defines.svh"

package pipe_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;

    // decode -> execute
    typedef struct packed {
        word_t             pc;
        isa_pkg::op_e      op;
        word_t             rs_val;
        word_t             rt_val;
        word_t             imm;     // already sign extended
        isa_pkg::reg_idx_t dest;
        logic              we;
    } dx_payload_t;

    // execute -> result
    typedef struct packed {
        word_t             pc;
        isa_pkg::op_e      op;
        word_t             alu_res;  // also the memory address
        word_t             store_data;
        isa_pkg::reg_idx_t dest;
        logic              we;
        logic              ovf;      // ADD overflowed, trap in result
    } xr_payload_t;

    typedef struct packed {
        word_t             pc;
        isa_pkg::reg_idx_t rd;
        word_t             data;
    } commit_t;

endpackage

// File: hdl/result_stage.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module result_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  pipe_pkg::xr_payload_t in_payload,
    input  logic                  commit_ready,
    output logic                  commit_valid,
    output pipe_pkg::word_t       commit_pc,
    output isa_pkg::reg_idx_t     commit_rd,
    output pipe_pkg::word_t       commit_data,
    output logic                  except,
    output pipe_pkg::word_t       except_pc,
    output logic                  commit_stall,
    output logic                  wb_we,
    output isa_pkg::reg_idx_t     wb_waddr,
    output pipe_pkg::word_t       wb_wdata
);

    localparam int AW = $clog2(`CORE_DMEM_WORDS);

    pipe_pkg::word_t   dmem [`CORE_DMEM_WORDS];
    logic [AW-1:0]     addr;
    pipe_pkg::commit_t rec;
    pipe_pkg::commit_t commit_q;
    logic              take;

    assign addr = in_payload.alu_res[AW+1:2];  // word addressed

    always_ff @(posedge clk) begin
        if (in_valid && in_payload.op == isa_pkg::OP_SW) begin
            dmem[addr] <= in_payload.store_data;
        end
    end

    assign except    = in_valid && in_payload.ovf;  // trapped ADD never commits
    assign except_pc = `CORE_EXC_VECTOR;

    assign rec.pc   = in_payload.pc;
    assign rec.rd   = in_payload.dest;
    assign rec.data = (in_payload.op == isa_pkg::OP_LW) ? dmem[addr] : in_payload.alu_res;

    // commit buffer, refilled as the consumer drains it
    assign commit_stall = commit_valid && !commit_ready;
    assign take         = in_valid && in_payload.we && !in_payload.ovf && !commit_stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            commit_valid <= 1'b0;
        end else if (!commit_stall) begin
            commit_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            commit_q <= rec;
        end
    end

    assign commit_pc   = commit_q.pc;
    assign commit_rd   = commit_q.rd;
    assign commit_data = commit_q.data;

    // regfile is written as the record enters the buffer
    assign wb_we    = take;
    assign wb_waddr = rec.rd;
    assign wb_wdata = rec.data;

    assert property (@(posedge clk) disable iff (!rst_n)
        commit_stall |=> commit_valid && $stable(commit_q));

endmodule

// File: hdl/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     out_valid,
    output payload_t out_payload
);

    // flush wins over a held stage
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            out_valid <= 1'b0;
        end else if (en) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            out_payload <= in_payload;
        end
    end

    // a killed slot stays empty until refilled by an enabled load
    assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !out_valid until_with en);

endmodule

// File: verification/pipe_core_tb.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module pipe_core_tb;

    localparam pipe_pkg::word_t exc_base = `CORE_EXC_VECTOR;

    logic              clk;
    logic              rst_n;
    logic              inst_valid;
    pipe_pkg::word_t   inst_pc;
    pipe_pkg::word_t   inst_word;
    logic              inst_ready;
    logic              commit_valid;
    pipe_pkg::word_t   commit_pc;
    isa_pkg::reg_idx_t commit_rd;
    pipe_pkg::word_t   commit_data;
    logic              commit_ready;
    logic              redirect_valid;
    pipe_pkg::word_t   redirect_pc;
    logic              redirect_exc;

    pipe_pkg::word_t   prog_pc [$];
    pipe_pkg::word_t   prog_word [$];
    pipe_pkg::commit_t exp_commit [$];
    pipe_pkg::word_t   exp_redir_pc [$];
    logic              exp_redir_exc [$];

    int              n_commits   = 0;
    int              n_redirects = 0;
    int              n_expected  = -1;
    logic            tables_done = 1'b0;
    integer          seed        = 56;
    pipe_pkg::word_t fetch_pc;

    tb_clock_gen clock_i (.clk(clk), .rst_n(rst_n));

    pipe_core pipe_core_i (
        .clk(clk), .rst_n(rst_n),
        .inst_valid(inst_valid), .inst_pc(inst_pc), .inst_word(inst_word),
        .inst_ready(inst_ready),
        .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_rd(commit_rd),
        .commit_data(commit_data), .commit_ready(commit_ready),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
        .redirect_exc(redirect_exc)
    );

    function automatic pipe_pkg::word_t encode_r(logic [5:0] fn, isa_pkg::reg_idx_t rd,
                                                 isa_pkg::reg_idx_t rs, isa_pkg::reg_idx_t rt);
        return {isa_pkg::OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic pipe_pkg::word_t encode_mul(isa_pkg::reg_idx_t rd,
                                                   isa_pkg::reg_idx_t rs, isa_pkg::reg_idx_t rt);
        return {isa_pkg::OPC_SPECIAL2, rs, rt, rd, 5'd0, isa_pkg::FN_MUL};
    endfunction

    function automatic pipe_pkg::word_t encode_i(logic [5:0] opc, isa_pkg::reg_idx_t rt,
                                                 isa_pkg::reg_idx_t rs, logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic int find_inst(pipe_pkg::word_t pc);
        int idx;
        idx = -1;
        foreach (prog_pc[i]) begin
            if (prog_pc[i] == pc) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic put_inst(pipe_pkg::word_t pc, pipe_pkg::word_t word);
        prog_pc.push_back(pc);
        prog_word.push_back(word);
    endtask

    task automatic expect_commit(pipe_pkg::word_t pc, isa_pkg::reg_idx_t rd,
                                 pipe_pkg::word_t data);
        pipe_pkg::commit_t rec;
        rec.pc   = pc;
        rec.rd   = rd;
        rec.data = data;
        exp_commit.push_back(rec);
    endtask

    task automatic expect_redirect(pipe_pkg::word_t pc, logic exc);
        exp_redir_pc.push_back(pc);
        exp_redir_exc.push_back(exc);
    endtask

    task automatic stop_with_failure(string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_commit(pipe_pkg::commit_t got, pipe_pkg::commit_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf(
                "Error at %0t: commit pc %h rd %0d data %h, expected pc %h rd %0d data %h",
                $time, got.pc, got.rd, got.data, exp.pc, exp.rd, exp.data));
        end
    endtask

    task automatic check_redirect(pipe_pkg::word_t got_pc, logic got_exc,
                                  pipe_pkg::word_t exp_pc, logic exp_exc);
        if (got_pc !== exp_pc || got_exc !== exp_exc) begin
            stop_with_failure($sformatf(
                "Error at %0t: redirect to %h exc %b, expected %h exc %b",
                $time, got_pc, got_exc, exp_pc, exp_exc));
        end
    endtask

    task automatic load_tables();
        // independent ALU and ADDIU
        put_inst(32'h00, encode_i(isa_pkg::OPC_ADDIU, 1, 0, 16'h0005));
        put_inst(32'h04, encode_i(isa_pkg::OPC_ADDIU, 2, 0, 16'hfffd));
        put_inst(32'h08, encode_i(isa_pkg::OPC_ADDIU, 3, 0, 16'h0100));
        put_inst(32'h0c, encode_i(isa_pkg::OPC_ADDIU, 4, 0, 16'h0f0f));
        put_inst(32'h10, encode_r(isa_pkg::FN_ADDU, 5, 1, 2));
        put_inst(32'h14, encode_r(isa_pkg::FN_SUBU, 6, 5, 1));  // uses $5 right away
        put_inst(32'h18, encode_r(isa_pkg::FN_AND, 7, 3, 4));
        put_inst(32'h1c, encode_r(isa_pkg::FN_OR, 8, 7, 1));
        put_inst(32'h20, encode_r(isa_pkg::FN_SLT, 9, 6, 1));
        put_inst(32'h24, encode_r(isa_pkg::FN_SLT, 10, 1, 6));
        // memory and load-use
        put_inst(32'h28, encode_i(isa_pkg::OPC_SW, 8, 1, 16'h0003));
        put_inst(32'h2c, encode_i(isa_pkg::OPC_LW, 11, 0, 16'h0008));
        put_inst(32'h30, encode_r(isa_pkg::FN_ADDU, 12, 11, 11));
        put_inst(32'h34, encode_i(isa_pkg::OPC_LW, 13, 0, 16'h0008));
        put_inst(32'h38, encode_r(isa_pkg::FN_SUBU, 14, 12, 13));  // load-use on rt
        // multiply
        put_inst(32'h3c, encode_i(isa_pkg::OPC_ADDIU, 15, 0, 16'h4000));
        put_inst(32'h40, encode_mul(16, 15, 15));
        put_inst(32'h44, encode_r(isa_pkg::FN_ADDU, 17, 16, 1));
        put_inst(32'h48, encode_mul(18, 2, 1));
        put_inst(32'h4c, encode_i(isa_pkg::OPC_ADDIU, 19, 18, 16'h0014));
        // branches, two untaken then two taken
        put_inst(32'h50, encode_i(isa_pkg::OPC_BEQ, 5, 1, 16'h0002));
        put_inst(32'h54, encode_i(isa_pkg::OPC_BNE, 5, 5, 16'h0002));
        put_inst(32'h58, encode_i(isa_pkg::OPC_BEQ, 1, 19, 16'h0002));
        put_inst(32'h5c, encode_i(isa_pkg::OPC_ADDIU, 3, 0, 16'h0001));
        put_inst(32'h60, encode_i(isa_pkg::OPC_ADDIU, 4, 0, 16'h0002));
        put_inst(32'h64, encode_i(isa_pkg::OPC_ADDIU, 22, 0, 16'h0007));
        put_inst(32'h68, encode_i(isa_pkg::OPC_BNE, 0, 22, 16'h0003));
        put_inst(32'h6c, encode_i(isa_pkg::OPC_ADDIU, 2, 0, 16'h0009));
        put_inst(32'h70, encode_i(isa_pkg::OPC_ADDIU, 3, 0, 16'h0009));
        put_inst(32'h74, encode_i(isa_pkg::OPC_ADDIU, 4, 0, 16'h0009));
        put_inst(32'h78, encode_r(isa_pkg::FN_ADDU, 24, 22, 2));
        // overflow trap, $1 must keep its value
        put_inst(32'h7c, encode_r(isa_pkg::FN_ADDU, 25, 16, 16));
        put_inst(32'h80, encode_r(isa_pkg::FN_ADDU, 25, 25, 25));
        put_inst(32'h84, encode_r(isa_pkg::FN_ADD, 1, 25, 25));
        put_inst(32'h88, encode_i(isa_pkg::OPC_ADDIU, 3, 0, 16'h0001));
        put_inst(32'h8c, encode_i(isa_pkg::OPC_ADDIU, 3, 0, 16'h0002));
        put_inst(exc_base, encode_r(isa_pkg::FN_ADDU, 29, 1, 3));
        put_inst(exc_base + 32'h4, encode_r(isa_pkg::FN_ADD, 30, 17, 19));
        put_inst(exc_base + 32'h8, encode_i(isa_pkg::OPC_SW, 30, 0, 16'h0010));
        put_inst(exc_base + 32'hc, encode_i(isa_pkg::OPC_LW, 31, 0, 16'h0010));
        put_inst(exc_base + 32'h10, encode_r(isa_pkg::FN_OR, 27, 31, 24));

        expect_commit(32'h00, 1, 32'h0000_0005);
        expect_commit(32'h04, 2, 32'hffff_fffd);
        expect_commit(32'h08, 3, 32'h0000_0100);
        expect_commit(32'h0c, 4, 32'h0000_0f0f);
        expect_commit(32'h10, 5, 32'h0000_0002);
        expect_commit(32'h14, 6, 32'hffff_fffd);
        expect_commit(32'h18, 7, 32'h0000_0100);
        expect_commit(32'h1c, 8, 32'h0000_0105);
        expect_commit(32'h20, 9, 32'h0000_0001);
        expect_commit(32'h24, 10, 32'h0000_0000);
        expect_commit(32'h2c, 11, 32'h0000_0105);
        expect_commit(32'h30, 12, 32'h0000_020a);
        expect_commit(32'h34, 13, 32'h0000_0105);
        expect_commit(32'h38, 14, 32'h0000_0105);
        expect_commit(32'h3c, 15, 32'h0000_4000);
        expect_commit(32'h40, 16, 32'h1000_0000);
        expect_commit(32'h44, 17, 32'h1000_0005);
        expect_commit(32'h48, 18, 32'hffff_fff1);  // -3 * 5
        expect_commit(32'h4c, 19, 32'h0000_0005);
        expect_commit(32'h64, 22, 32'h0000_0007);
        expect_commit(32'h78, 24, 32'h0000_0004);
        expect_commit(32'h7c, 25, 32'h2000_0000);
        expect_commit(32'h80, 25, 32'h4000_0000);
        expect_commit(exc_base, 29, 32'h0000_0105);
        expect_commit(exc_base + 32'h4, 30, 32'h1000_000a);
        expect_commit(exc_base + 32'hc, 31, 32'h1000_000a);
        expect_commit(exc_base + 32'h10, 27, 32'h1000_000e);

        expect_redirect(32'h64, 1'b0);
        expect_redirect(32'h78, 1'b0);
        expect_redirect(exc_base, 1'b1);
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        load_tables();
        n_expected  = exp_commit.size();
        tables_done = 1'b1;
        wait (n_commits == n_expected);
        repeat (20) @(posedge clk);  // room for a stray commit or redirect
        if (n_redirects != exp_redir_pc.size()) begin
            stop_with_failure($sformatf("only %0d of %0d expected redirects were seen",
                                        n_redirects, exp_redir_pc.size()));
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

    // fetcher, restarts at every redirect
    initial begin
        int idx;
        inst_valid = 1'b0;
        inst_pc    = '0;
        inst_word  = '0;
        fetch_pc   = '0;
        @(posedge rst_n);
        forever begin
            idx     = find_inst(fetch_pc);
            inst_pc = fetch_pc;
            if (idx >= 0) begin
                inst_valid = 1'b1;
                inst_word  = prog_word[idx];
            end else begin
                inst_valid = 1'b0;  // past the end of the program
                inst_word  = '0;
            end
            @(posedge clk);
            if (redirect_valid) begin
                if (n_redirects >= exp_redir_pc.size()) begin
                    stop_with_failure($sformatf("unexpected redirect to %h at %0t",
                                                redirect_pc, $time));
                end else begin
                    check_redirect(redirect_pc, redirect_exc,
                                   exp_redir_pc[n_redirects], exp_redir_exc[n_redirects]);
                    n_redirects++;
                end
                fetch_pc = redirect_pc;
            end else if (inst_valid && inst_ready) begin
                fetch_pc = fetch_pc + 4;
            end
            @(negedge clk);
        end
    end

    initial begin
        commit_ready = 1'b1;
        forever begin
            @(negedge clk);
            commit_ready = ($random(seed) & 3) != 0;  // about one stall in four
        end
    end

    always @(posedge clk) begin
        pipe_pkg::commit_t got;
        if (rst_n && commit_valid && commit_ready) begin
            got.pc   = commit_pc;
            got.rd   = commit_rd;
            got.data = commit_data;
            if (n_commits >= exp_commit.size()) begin
                stop_with_failure($sformatf("unexpected extra commit from pc %h at %0t",
                                            commit_pc, $time));
            end else begin
                check_commit(got, exp_commit[n_commits]);
                n_commits++;
            end
        end
    end

    // watchdog scaled by program and commit count
    initial begin
        int limit_ns;
        wait (tables_done);
        limit_ns = (prog_pc.size() + exp_commit.size()) * (`CORE_MUL_CYCLES + 4) * 40 * 4;
        #(limit_ns);
        stop_with_failure($sformatf("timeout after %0d ns, %0d of %0d commits seen",
                                    limit_ns, n_commits, exp_commit.size()));
    end

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // reset held over four rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule
